// File: source/spectrum_mem_pkg.sv
`default_nettype none

package spectrum_mem_pkg;

	// ====================
	// Widths

	// Bit 17 set means the ROM region
	typedef logic [17:0] mem_addr_t;
	typedef logic [2:0]  page_t;
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;

	// ====================
	// System memory map

	// ROM page 0 at the base, ROM page 1 at base plus 4000
	localparam mem_addr_t ROM_BASE = 18'h20000;
	localparam mem_addr_t RAM_BASE = 18'h00000;

	// 16K pages
	localparam int PAGE_SIZE_BITS = 14;

	// Fixed RAM pages of the 128K map
	localparam page_t SCREEN_PAGE = 3'd5;
	localparam page_t SHADOW_PAGE = 3'd7;
	localparam page_t MID_PAGE    = 3'd2;

	// Owner of the single memory port
	typedef enum logic {
		grant_cpu,
		grant_loader
	} grant_e;

endpackage

`default_nettype wire

// File: source/spectrum_io_pkg.sv
`default_nettype none

package spectrum_io_pkg;

	// ====================
	// Port data types

	typedef logic [2:0] border_t;

	// Keys are active low
	typedef logic [4:0] key_row_t;

	// Right, left, down, up, fire1, fire2 from bit 0 upward, active high
	typedef logic [5:0] joy_t;

	localparam int KEY_ROWS = 8;

	// ====================
	// Port decode

	// Compared with A5..A0
	localparam logic [5:0] KEMPSTON_PORT = 6'h1F;

	// 7FFD answers whenever A15 and A1 are both low
	localparam logic [15:0] PAGE_PORT_MASK = 16'h8002;

	// Floating data bus
	localparam logic [7:0] IDLE_BUS = 8'hFF;

endpackage

`default_nettype wire

// File: source/cpu_bus_interface.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_interface
	import spectrum_mem_pkg::*, spectrum_io_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  cpu_addr_t cpu_addr,
	input  logic      mreq_n,
	input  logic      iorq_n,
	input  logic      rd_n,
	input  logic      wr_n,
	input  logic      m1_n,
	input  byte_t     mem_dout,
	input  byte_t     port_dout,
	input  logic      port_hit,
	output logic      io_write,
	output logic      mem_write,
	output logic      mem_read,
	output byte_t     cpu_din
);

	logic      io_wr;
	logic      io_rd;
	logic      mem_wr;
	logic      io_wr_q;
	logic      mem_wr_q;
	logic      mem_rd_q;
	logic      new_addr;
	cpu_addr_t addr_q;

	// I/O cycles exclude interrupt acknowledge
	assign io_wr    = !iorq_n && !wr_n && m1_n;
	assign io_rd    = !iorq_n && !rd_n && m1_n;
	assign mem_wr   = !mreq_n && !wr_n;
	assign mem_read = !mreq_n && !rd_n;

	// New write on the strobe edge or when the address moves under a held strobe
	assign new_addr  = cpu_addr != addr_q;
	assign io_write  = io_wr && (!io_wr_q || new_addr);
	assign mem_write = mem_wr && (!mem_wr_q || new_addr);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q  <= 1'b0;
			mem_wr_q <= 1'b0;
			mem_rd_q <= 1'b0;
		end else begin
			io_wr_q  <= io_wr;
			mem_wr_q <= mem_wr;
			mem_rd_q <= mem_read;
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_q <= cpu_addr;
	end

	// Memory data trails the request by one clock, so its select is delayed too
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cpu_din <= IDLE_BUS;
		end else if (mem_rd_q) begin
			cpu_din <= mem_dout;
		end else if (io_rd && port_hit) begin
			cpu_din <= port_dout;
		end else begin
			cpu_din <= IDLE_BUS;
		end
	end

endmodule

`default_nettype wire

// File: source/page_control.sv
`timescale 1ns/1ps
`default_nettype none

module page_control
	import spectrum_mem_pkg::*, spectrum_io_pkg::*;
#(
	parameter int RAM_PAGE_BITS = 3
) (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      model_48k,
	input  cpu_addr_t cpu_addr,
	input  byte_t     cpu_dout,
	input  logic      io_write,
	output mem_addr_t mem_addr,
	output logic      rom_area,
	output logic      shadow_screen
);

	// Page bits beyond the fitted RAM are dropped
	localparam page_t PAGE_MASK = page_t'((1 << RAM_PAGE_BITS) - 1);

	logic                      zx48;
	page_t                     page_sel;
	logic                      page_scr;
	logic                      page_rom;
	logic                      page_lock;
	logic                      page_write;
	page_t                     screen_page;
	logic [PAGE_SIZE_BITS-1:0] offset;

	function automatic mem_addr_t ram_page(input page_t page,
		input logic [PAGE_SIZE_BITS-1:0] ofs);
		ram_page = RAM_BASE + {1'b0, page & PAGE_MASK, ofs};
	endfunction

	// ====================
	// Port 7FFD

	assign page_write = io_write && ((cpu_addr & PAGE_PORT_MASK) == '0) &&
		!zx48 && !page_lock;

	// Machine model is sampled only while reset is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			zx48      <= model_48k;
			page_sel  <= '0;
			page_scr  <= 1'b0;
			page_rom  <= 1'b0;
			page_lock <= 1'b0;
		end else if (page_write) begin
			page_sel  <= cpu_dout[2:0];
			page_scr  <= cpu_dout[3];
			page_rom  <= cpu_dout[4];
			page_lock <= cpu_dout[5];
		end
	end

	// Screen page shown by the video side
	assign screen_page   = page_scr ? SHADOW_PAGE : SCREEN_PAGE;
	assign shadow_screen = screen_page == SHADOW_PAGE;

	// ====================
	// Address translation

	assign offset   = cpu_addr[PAGE_SIZE_BITS-1:0];
	assign rom_area = cpu_addr[15:14] == 2'b00;

	always_comb begin
		case (cpu_addr[15:14])
			// 48K always sees the BASIC ROM in page 1
			2'b00:   mem_addr = ROM_BASE + {3'b000, zx48 | page_rom, offset};
			2'b01:   mem_addr = ram_page(SCREEN_PAGE, offset);
			2'b10:   mem_addr = ram_page(MID_PAGE, offset);
			default: mem_addr = ram_page(page_sel, offset);
		endcase
	end

endmodule

`default_nettype wire

// File: source/ula_ports.sv
`timescale 1ns/1ps
`default_nettype none

module ula_ports
	import spectrum_mem_pkg::*, spectrum_io_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  cpu_addr_t               cpu_addr,
	input  byte_t                   cpu_dout,
	input  logic                    io_write,
	input  logic                    iorq_n,
	input  logic                    rd_n,
	input  logic                    m1_n,
	input  key_row_t [KEY_ROWS-1:0] key_matrix,
	input  joy_t                    joystick,
	input  logic                    tape_in,
	output byte_t                   port_dout,
	output logic                    port_hit,
	output border_t                 border,
	output logic                    ear_out,
	output logic                    mic_out
);

	logic     io_read;
	logic     ula_sel;
	logic     kemp_sel;
	key_row_t key_data;

	// ULA on any even port
	assign io_read  = !iorq_n && !rd_n && m1_n;
	assign ula_sel  = !cpu_addr[0];
	assign kemp_sel = cpu_addr[5:0] == KEMPSTON_PORT;
	assign port_hit = io_read && (ula_sel || kemp_sel);

	// A low bit among A8..A15 selects that half-row
	always_comb begin
		key_data = '1;
		for (int row = 0; row < KEY_ROWS; row++) begin
			if (!cpu_addr[8 + row]) begin
				key_data = key_data & key_matrix[row];
			end
		end
	end

	assign port_dout = ula_sel ? {1'b1, tape_in, 1'b1, key_data} : {2'b00, joystick};

	// ====================
	// Port FE write

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border  <= '0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (io_write && ula_sel) begin
			border  <= cpu_dout[2:0];
			mic_out <= cpu_dout[3];
			ear_out <= cpu_dout[4];
		end
	end

endmodule

`default_nettype wire

// File: source/image_loader.sv
`timescale 1ns/1ps
`default_nettype none

module image_loader
	import spectrum_mem_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      ioctl_download,
	input  logic      ioctl_wr,
	input  mem_addr_t ioctl_addr,
	input  logic      ioctl_index,
	input  byte_t     ioctl_dout,
	output logic      load_req,
	output mem_addr_t load_addr,
	output byte_t     load_data,
	output logic      bus_request
);

	mem_addr_t region_base;

	// Index 0 carries the ROM image, index 1 a RAM image
	assign region_base = ioctl_index ? RAM_BASE : ROM_BASE;

	// CPU stays off the bus for the whole download
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_req    <= 1'b0;
			bus_request <= 1'b0;
		end else begin
			load_req    <= ioctl_wr;
			bus_request <= ioctl_download;
		end
	end

	always_ff @(posedge clk_sys) begin
		load_addr <= region_base + ioctl_addr;
		load_data <= ioctl_dout;
	end

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
	import spectrum_mem_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      load_req,
	input  mem_addr_t load_addr,
	input  byte_t     load_data,
	input  mem_addr_t cpu_mem_addr,
	input  byte_t     cpu_data,
	input  logic      mem_write,
	input  logic      rom_area,
	input  logic      bus_request,
	output mem_addr_t ram_addr,
	output byte_t     ram_din,
	output logic      ram_we
);

	grant_e grant;
	grant_e grant_q;
	logic   cpu_we;

	// Loader always wins, CPU requests under it are lost
	assign grant = load_req ? grant_loader : grant_cpu;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			grant_q <= grant_cpu;
		end else begin
			grant_q <= grant;
		end
	end

	// ROM is read-only to the CPU
	// No CPU write in the turnaround clock after a loader cycle
	assign cpu_we = mem_write && !rom_area && !bus_request && (grant_q == grant_cpu);

	always_comb begin
		if (grant == grant_loader) begin
			ram_addr = load_addr;
			ram_din  = load_data;
			ram_we   = 1'b1;
		end else begin
			ram_addr = cpu_mem_addr;
			ram_din  = cpu_data;
			ram_we   = cpu_we;
		end
	end

endmodule

`default_nettype wire

// File: source/system_ram.sv
`timescale 1ns/1ps
`default_nettype none

module system_ram
	import spectrum_mem_pkg::*;
#(
	parameter int RAM_PAGE_BITS = 3
) (
	input  logic      clk_sys,
	input  mem_addr_t ram_addr,
	input  byte_t     ram_din,
	input  logic      ram_we,
	output byte_t     ram_dout
);

	localparam int RAM_WORDS = 1 << (RAM_PAGE_BITS + PAGE_SIZE_BITS);
	localparam int ROM_WORDS = 2 << PAGE_SIZE_BITS;
	localparam int DEPTH     = RAM_WORDS + ROM_WORDS;
	localparam int IDX_BITS  = $clog2(DEPTH);

	byte_t               mem [DEPTH];
	logic [IDX_BITS-1:0] index;

	// Two ROM pages stacked above the RAM pages; high RAM bits alias
	always_comb begin
		if (ram_addr >= ROM_BASE) begin
			index = IDX_BITS'(RAM_WORDS) + IDX_BITS'(ram_addr[PAGE_SIZE_BITS:0]);
		end else begin
			index = IDX_BITS'(ram_addr[RAM_PAGE_BITS+PAGE_SIZE_BITS-1:0]);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[index] <= ram_din;
		end
		ram_dout <= mem[index];
	end

endmodule

`default_nettype wire

// File: source/spectrum_core.sv
`timescale 1ns/1ps
`default_nettype none

module spectrum_core
	import spectrum_mem_pkg::*, spectrum_io_pkg::*;
#(
	parameter int RAM_PAGE_BITS = 3
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      model_48k,

	// Z80 bus
	input  cpu_addr_t                 cpu_addr,
	input  byte_t                     cpu_dout,
	input  logic                      mreq_n,
	input  logic                      iorq_n,
	input  logic                      rd_n,
	input  logic                      wr_n,
	input  logic                      m1_n,
	output byte_t                     cpu_din,
	output logic                      bus_request,

	// Image download
	input  logic                      ioctl_download,
	input  logic                      ioctl_wr,
	input  mem_addr_t                 ioctl_addr,
	input  logic                      ioctl_index,
	input  byte_t                     ioctl_dout,

	// ULA and joystick
	input  key_row_t [KEY_ROWS-1:0]   key_matrix,
	input  joy_t                      joystick,
	input  logic                      tape_in,
	output border_t                   border,
	output logic                      ear_out,
	output logic                      mic_out,
	output logic                      shadow_screen
);

	logic      io_write;
	logic      mem_write;
	byte_t     port_dout;
	logic      port_hit;
	mem_addr_t cpu_mem_addr;
	logic      rom_area;
	logic      load_req;
	mem_addr_t load_addr;
	byte_t     load_data;
	mem_addr_t ram_addr;
	byte_t     ram_din;
	logic      ram_we;
	byte_t     ram_dout;

	cpu_bus_interface cpu_bus (
		.clk_sys, .reset, .cpu_addr,
		.mreq_n, .iorq_n, .rd_n, .wr_n, .m1_n,
		.mem_dout  (ram_dout),
		.port_dout, .port_hit,
		.io_write, .mem_write,
		.mem_read  (),
		.cpu_din
	);

	page_control #(.RAM_PAGE_BITS(RAM_PAGE_BITS)) paging (
		.clk_sys, .reset, .model_48k, .cpu_addr, .cpu_dout, .io_write,
		.mem_addr  (cpu_mem_addr),
		.rom_area, .shadow_screen
	);

	ula_ports ula (
		.clk_sys, .reset, .cpu_addr, .cpu_dout, .io_write,
		.iorq_n, .rd_n, .m1_n,
		.key_matrix, .joystick, .tape_in,
		.port_dout, .port_hit, .border, .ear_out, .mic_out
	);

	image_loader loader (
		.clk_sys, .reset, .ioctl_download, .ioctl_wr,
		.ioctl_addr, .ioctl_index, .ioctl_dout,
		.load_req, .load_addr, .load_data, .bus_request
	);

	mem_arbiter arbiter (
		.clk_sys, .reset, .load_req, .load_addr, .load_data,
		.cpu_mem_addr,
		.cpu_data  (cpu_dout),
		.mem_write, .rom_area, .bus_request,
		.ram_addr, .ram_din, .ram_we
	);

	system_ram #(.RAM_PAGE_BITS(RAM_PAGE_BITS)) ram (
		.clk_sys, .ram_addr, .ram_din, .ram_we, .ram_dout
	);

endmodule

`default_nettype wire

// File: dv/spectrum_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module spectrum_core_asserts (
	input logic       clk_sys,
	input logic       reset,
	input logic       ioctl_download,
	input logic       bus_request,
	input logic       io_write,
	input logic [2:0] border,
	input logic       ear_out,
	input logic       mic_out,
	input logic       shadow_screen
);

	int failures = 0;

	// Download level shows on bus_request after one register
	property bus_request_follows;
		@(posedge clk_sys) disable iff (reset)
		!$past(reset) |-> bus_request == $past(ioctl_download);
	endproperty

	// ULA outputs cleared by reset
	property outputs_cleared;
		@(posedge clk_sys)
		$past(reset) |-> border == 3'b000 && !ear_out && !mic_out;
	endproperty

	// Port outputs only move after a port write
	property outputs_hold;
		@(posedge clk_sys) disable iff (reset)
		!$past(reset) && !$past(io_write) |->
			$stable(border) && $stable(ear_out) && $stable(mic_out) && $stable(shadow_screen);
	endproperty

	assert property (bus_request_follows) else begin
		$error("bus_request does not follow ioctl_download by one clock");
		failures++;
	end

	assert property (outputs_cleared) else begin
		$error("border, ear_out or mic_out not cleared after reset");
		failures++;
	end

	assert property (outputs_hold) else begin
		$error("port output changed without an I/O write");
		failures++;
	end

endmodule

bind spectrum_core spectrum_core_asserts port_checks (
	.clk_sys        (clk_sys),
	.reset          (reset),
	.ioctl_download (ioctl_download),
	.bus_request    (bus_request),
	.io_write       (io_write),
	.border         (border),
	.ear_out        (ear_out),
	.mic_out        (mic_out),
	.shadow_screen  (shadow_screen)
);

`default_nettype wire

// File: dv/spectrum_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spectrum_core_tb;

	localparam int TIMEOUT_CYCLES = 50;
	// Bytes downloaded at the start of every page
	localparam int PAGE_BYTES = 16;
	localparam int ROM_REGION = 'h20000;
	localparam int PAGE_SPAN  = 'h4000;

	logic            clk_sys;
	logic            reset;
	logic            model_48k;
	logic [15:0]     cpu_addr;
	logic [7:0]      cpu_dout;
	logic            mreq_n;
	logic            iorq_n;
	logic            rd_n;
	logic            wr_n;
	logic            m1_n;
	logic [7:0]      cpu_din;
	logic            bus_request;
	logic            ioctl_download;
	logic            ioctl_wr;
	logic [17:0]     ioctl_addr;
	logic            ioctl_index;
	logic [7:0]      ioctl_dout;
	logic [7:0][4:0] key_matrix;
	logic [5:0]      joystick;
	logic            tape_in;
	logic [2:0]      border;
	logic            ear_out;
	logic            mic_out;
	logic            shadow_screen;

	integer seed;
	int     checks;
	int     errors;

	// Reference model of memory contents and the 7FFD register
	logic [7:0] ref_mem [int];
	logic [2:0] ref_page;
	logic       ref_rom;
	logic       ref_scr;
	logic       ref_lock;
	logic       ref_48k;

	spectrum_core #(.RAM_PAGE_BITS(3)) uut (.*);

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	// System address that a CPU address should reach
	function automatic int map_address(input logic [15:0] addr);
		int ofs;
		ofs = addr[13:0];
		case (addr[15:14])
			2'd0:    map_address = ROM_REGION + ((ref_48k || ref_rom) ? PAGE_SPAN : 0) + ofs;
			2'd1:    map_address = 5 * PAGE_SPAN + ofs;
			2'd2:    map_address = 2 * PAGE_SPAN + ofs;
			default: map_address = ref_page * PAGE_SPAN + ofs;
		endcase
	endfunction

	function automatic logic [7:0] ula_expect(input logic [7:0] high);
		logic [4:0] keys;
		keys = 5'h1F;
		for (int row = 0; row < 8; row++) begin
			if (!high[row]) begin
				keys = keys & key_matrix[row];
			end
		end
		ula_expect = {1'b1, tape_in, 1'b1, keys};
	endfunction

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic wait_clocks(input int count);
		repeat (count) @(negedge clk_sys);
	endtask

	task automatic wait_bus_request(input logic level);
		int count;
		count = 0;
		while (bus_request !== level && count < TIMEOUT_CYCLES) begin
			@(negedge clk_sys);
			count++;
		end
		if (bus_request !== level) begin
			$display("Timeout while waiting for bus_request to become %0d", level);
			$display("STATUS: FAIL");
			$finish;
		end
	endtask

	task automatic apply_reset(input logic model);
		@(negedge clk_sys);
		reset     = 1'b1;
		model_48k = model;
		wait_clocks(10);
		reset    = 1'b0;
		ref_page = 3'd0;
		ref_rom  = 1'b0;
		ref_scr  = 1'b0;
		ref_lock = 1'b0;
		ref_48k  = model;
	endtask

	task automatic load_byte(input logic index, input int addr, input logic [7:0] data);
		@(negedge clk_sys);
		ioctl_index = index;
		ioctl_addr  = 18'(addr);
		ioctl_dout  = data;
		ioctl_wr    = 1'b1;
		check_value("bus_request", bus_request, 8'h01);
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		ref_mem[(index ? 0 : ROM_REGION) + addr] = data;
	endtask

	task automatic write_memory(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk_sys);
		cpu_addr = addr;
		cpu_dout = data;
		mreq_n   = 1'b0;
		wr_n     = 1'b0;
		@(negedge clk_sys);
		mreq_n = 1'b1;
		wr_n   = 1'b1;
		// ROM window is read-only
		if (addr[15:14] != 2'd0) begin
			ref_mem[map_address(addr)] = data;
		end
		@(negedge clk_sys);
	endtask

	task automatic read_memory(input logic [15:0] addr, output logic [7:0] data);
		@(negedge clk_sys);
		cpu_addr = addr;
		mreq_n   = 1'b0;
		rd_n     = 1'b0;
		// One clock in memory, one in the read register
		wait_clocks(2);
		data   = cpu_din;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic expect_memory(input logic [15:0] addr);
		logic [7:0] got;
		read_memory(addr, got);
		if (!ref_mem.exists(map_address(addr))) begin
			$display("Read of address %h has no known contents", addr);
			errors++;
		end else begin
			check_value("cpu_din", got, ref_mem[map_address(addr)]);
		end
	endtask

	task automatic write_port(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk_sys);
		cpu_addr = addr;
		cpu_dout = data;
		iorq_n   = 1'b0;
		wr_n     = 1'b0;
		@(negedge clk_sys);
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		if (addr[15] == 1'b0 && addr[1] == 1'b0 && !ref_48k && !ref_lock) begin
			ref_page = data[2:0];
			ref_scr  = data[3];
			ref_rom  = data[4];
			ref_lock = data[5];
		end
		@(negedge clk_sys);
	endtask

	task automatic read_port(input logic [15:0] addr, output logic [7:0] data);
		@(negedge clk_sys);
		cpu_addr = addr;
		iorq_n   = 1'b0;
		rd_n     = 1'b0;
		@(negedge clk_sys);
		data   = cpu_din;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		@(negedge clk_sys);
	endtask

	initial begin : stimulus
		logic [7:0] data;
		logic [7:0] got;
		logic [7:0] high;
		int         page;
		int         ofs;
		int         i;

		seed           = 5;
		checks         = 0;
		errors         = 0;
		reset          = 1'b1;
		model_48k      = 1'b0;
		cpu_addr       = 16'h0000;
		cpu_dout       = 8'h00;
		mreq_n         = 1'b1;
		iorq_n         = 1'b1;
		rd_n           = 1'b1;
		wr_n           = 1'b1;
		m1_n           = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_index    = 1'b0;
		ioctl_dout     = 8'h00;
		key_matrix     = '1;
		joystick       = '0;
		tape_in        = 1'b0;
		apply_reset(1'b0);

		// ====================
		// Download and read-back
		@(negedge clk_sys);
		ioctl_download = 1'b1;
		wait_bus_request(1'b1);
		for (page = 0; page < 2; page++) begin
			for (ofs = 0; ofs < PAGE_BYTES; ofs++) begin
				load_byte(1'b0, page * PAGE_SPAN + ofs, 8'($random(seed)));
			end
		end
		for (page = 0; page < 8; page++) begin
			for (ofs = 0; ofs < PAGE_BYTES; ofs++) begin
				load_byte(1'b1, page * PAGE_SPAN + ofs, 8'($random(seed)));
			end
		end
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		wait_bus_request(1'b0);
		expect_memory(16'h0000);
		expect_memory(16'h0009);
		expect_memory(16'h4003);
		expect_memory(16'h800E);

		// ====================
		// 128K paging, shadow screen on odd pages
		for (page = 0; page < 8; page++) begin
			write_port(16'h7FFD, {4'b0000, page[0], page[2:0]});
			check_value("shadow_screen", shadow_screen, ref_scr);
			write_memory(16'hC000 + 16'(page), 8'($random(seed)));
			expect_memory(16'hC000 + 16'(page));
			// Downloaded byte of the selected page
			expect_memory(16'hC008 + 16'(page));
			if (page == 5) begin
				expect_memory(16'h4005);
			end
			if (page == 2) begin
				expect_memory(16'h8002);
			end
		end
		write_port(16'h7FFD, 8'h10);
		expect_memory(16'h0005);
		write_port(16'h7FFD, 8'h00);
		expect_memory(16'h0005);

		// ====================
		// Lock and ROM protection
		write_port(16'h7FFD, 8'h3B);
		write_port(16'h7FFD, 8'h04);
		check_value("shadow_screen", shadow_screen, ref_scr);
		expect_memory(16'hC003);
		expect_memory(16'h0002);
		write_memory(16'h0002, 8'($random(seed)));
		write_memory(16'h0007, 8'($random(seed)));
		expect_memory(16'h0002);
		expect_memory(16'h0007);
		apply_reset(1'b0);
		write_port(16'h7FFD, 8'h04);
		expect_memory(16'hC004);

		// ====================
		// ULA port FE
		for (i = 0; i < 6; i++) begin
			data = 8'($random(seed));
			write_port(16'h00FE, data);
			check_value("border", {5'b00000, border}, {5'b00000, data[2:0]});
			check_value("mic_out", mic_out, data[3]);
			check_value("ear_out", ear_out, data[4]);
			key_matrix = 40'({$random(seed), $random(seed)});
			tape_in    = 1'($random(seed));
			high       = (i == 0) ? 8'hFF : 8'($random(seed));
			read_port({high, 8'hFE}, got);
			check_value("cpu_din", got, ula_expect(high));
		end

		// Kempston joystick and undecoded ports
		for (i = 0; i < 3; i++) begin
			joystick = 6'($random(seed));
			read_port(16'h001F, got);
			check_value("cpu_din", got, {2'b00, joystick});
		end
		read_port(16'h00FF, got);
		check_value("cpu_din", got, 8'hFF);
		read_port(16'h7FFD, got);
		check_value("cpu_din", got, 8'hFF);

		// ====================
		// 48K mode
		write_port(16'h00FE, 8'h1F);
		apply_reset(1'b1);
		check_value("border", {5'b00000, border}, 8'h00);
		expect_memory(16'h0004);
		write_port(16'h7FFD, 8'h0F);
		check_value("shadow_screen", shadow_screen, 8'h00);
		expect_memory(16'hC006);
		expect_memory(16'h0004);

		wait_clocks(2);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, uut.port_checks.failures);
		if (errors == 0 && uut.port_checks.failures == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: spectrum_core.f
source/spectrum_mem_pkg.sv
source/spectrum_io_pkg.sv
source/cpu_bus_interface.sv
source/page_control.sv
source/ula_ports.sv
source/image_loader.sv
source/mem_arbiter.sv
source/system_ram.sv
source/spectrum_core.sv
dv/spectrum_core_asserts.sv
dv/spectrum_core_tb.sv
